/* rtl/memtest_pkg.sv */
// Shared clk_gui types and constants; all counters wrap silently and no field is saturated
`default_nettype none

package memtest_pkg;

    ////////////////////
    // Tuning constants
    ////////////////////

    localparam int unsigned CLK_GUI_HZ        = 50000000; // Default ticks per second
    localparam int unsigned DEBOUNCE_BITS_DEF = 16;       // 2^16 cycles, about 1.3 ms at 50 MHz
    localparam int unsigned STEP_GAP          = 4;        // Quiet cycles between PLL steps
    localparam int unsigned PENDING_W         = 9;        // Signed, so +-255 deferred steps
    localparam int unsigned LED_W             = 4;        // Board LEDs

    ////////////////////
    // Plain vectors
    ////////////////////

    typedef logic [31:0] count_t;     // Pass or fail count
    typedef logic [15:0] secs_t;      // Binary seconds since reset
    typedef logic [15:0] bcd_mins_t;  // Four BCD digits, 9999 max
    typedef logic [7:0]  phase_t;     // Phase count shown to the user

    // Steps counted by the buttons but not yet sent to the PLL
    typedef logic signed [PENDING_W-1:0] pending_t;

    ////////////////////
    // Grouped outputs
    ////////////////////

    typedef struct packed {
        secs_t     secs;              // Binary seconds
        bcd_mins_t mins;              // BCD minutes
    } elapsed_t;                      // 32 bits

    typedef struct packed {
        count_t passcount;
        count_t failcount;
        logic   first_fail_valid;     // Sticky until reset
        secs_t  first_fail_secs;      // Time of first failure
    } tally_t;                        // 81 bits

    typedef struct packed {
        phase_t phase;                // Display only
        logic   phasedir;             // High means step up
        logic   phasestep;            // One cycle per step
        logic   phaseloadreg;         // One cycle after the burst
    } pll_ctrl_t;                     // 11 bits

    // Stepper FSM
    typedef enum logic [2:0] {
        IDLE,
        WAIT_RELEASE,
        STEP,
        GAP,
        LOAD
    } step_state_t;

endpackage

`default_nettype wire

/* rtl/btn_debounce.sv */
// Raw button may be async; output lags a clean change by 2 + 2^debounce_bits clk_gui cycles
`timescale 1ns/100ps
`default_nettype none

module btn_debounce #(
    parameter int unsigned debounce_bits = memtest_pkg::DEBOUNCE_BITS_DEF
) (
    input  wire logic clk_gui,
    input  wire logic timer_reset,
    input  wire logic btn,            // Raw pin level
    output logic      level           // Debounced level
);

    logic [1:0]               sync_q; // Two-flop synchronizer
    logic [debounce_bits-1:0] stable_cnt;
    logic                     differs;
    logic                     stable_done;

    ////////////////////
    // Synchronizer
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], btn}; // sync_q[1] is safe to use
        end
    end

    ////////////////////
    // Stability counter
    ////////////////////

    always_comb begin
        differs     = (sync_q[1] != level);
        stable_done = (stable_cnt == '1); // 2^debounce_bits-th differing cycle
    end

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (!differs) begin
            stable_cnt <= '0;             // Bounce back restarts the wait
        end else if (stable_done) begin
            stable_cnt <= '0;
            level      <= sync_q[1];      // Accept the new value
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/pll_phase_stepper.sv */
// Levels must be debounced; more than 255 deferred steps wrap the pending count and lose steps
`timescale 1ns/100ps
`default_nettype none

module pll_phase_stepper (
    input  wire logic              clk_gui,
    input  wire logic              timer_reset,
    input  wire logic              inc_level,    // Debounced "phase up" button
    input  wire logic              dec_level,    // Debounced "phase down" button
    output memtest_pkg::pll_ctrl_t pll_ctrl
);

    localparam int unsigned GAP_W = $clog2(memtest_pkg::STEP_GAP + 1);

    memtest_pkg::step_state_t state;
    memtest_pkg::phase_t      phase_q;
    memtest_pkg::pending_t    pending;           // Positive means steps up owed
    memtest_pkg::pending_t    press_delta;       // +1, -1 or 0 from the buttons
    memtest_pkg::pending_t    step_delta;        // Moves pending toward zero
    logic [GAP_W-1:0]         gap_cnt;
    logic                     inc_q;
    logic                     dec_q;
    logic                     dir_q;             // Direction of the current burst
    logic                     inc_rise;
    logic                     dec_rise;
    logic                     btn_idle;          // Both buttons released
    logic                     step_fire;
    logic                     gap_done;

    ////////////////////
    // Press detection
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            inc_q <= 1'b0;
            dec_q <= 1'b0;
        end else begin
            inc_q <= inc_level;
            dec_q <= dec_level;
        end
    end

    always_comb begin
        inc_rise  = inc_level & ~inc_q;
        dec_rise  = dec_level & ~dec_q;
        btn_idle  = ~inc_level & ~dec_level;
        // Step only while nobody touches a button
        step_fire = (state == memtest_pkg::STEP) && btn_idle;
        gap_done  = (gap_cnt == GAP_W'(memtest_pkg::STEP_GAP - 1));

        press_delta = '0;
        if (inc_rise && !dec_rise) begin
            press_delta = memtest_pkg::pending_t'(1);
        end else if (dec_rise && !inc_rise) begin
            press_delta = '1;                    // -1; both at once is ignored
        end

        step_delta = '0;
        if (step_fire) begin
            step_delta = dir_q ? '1 : memtest_pkg::pending_t'(1);
        end
    end

    // Display count moves at once, wraps at 8 bits
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + memtest_pkg::phase_t'(press_delta);
        end
    end

    ////////////////////
    // Step FSM
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            state   <= memtest_pkg::IDLE;
            pending <= '0;
            gap_cnt <= '0;
            dir_q   <= 1'b0;
        end else begin
            pending <= pending + press_delta + step_delta; // Presses keep adding mid-burst
            case (state)
                memtest_pkg::IDLE: begin
                    if (pending != '0) begin
                        state <= memtest_pkg::WAIT_RELEASE;
                    end
                end
                memtest_pkg::WAIT_RELEASE: begin
                    if (btn_idle) begin
                        if (pending == '0) begin
                            state <= memtest_pkg::LOAD;  // Presses cancelled out
                        end else begin
                            state <= memtest_pkg::STEP;
                            dir_q <= ~pending[memtest_pkg::PENDING_W-1];
                        end
                    end
                end
                memtest_pkg::STEP: begin
                    gap_cnt <= '0;
                    // A press landing here defers the step
                    state   <= step_fire ? memtest_pkg::GAP : memtest_pkg::WAIT_RELEASE;
                end
                memtest_pkg::GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_done) begin
                        if (pending == '0) begin
                            state <= memtest_pkg::LOAD;  // Burst finished
                        end else if (btn_idle) begin
                            state <= memtest_pkg::STEP;
                            dir_q <= ~pending[memtest_pkg::PENDING_W-1];
                        end else begin
                            state <= memtest_pkg::WAIT_RELEASE; // Held press pauses burst
                        end
                    end
                end
                memtest_pkg::LOAD: begin
                    state <= memtest_pkg::IDLE;
                end
                default: begin
                    state <= memtest_pkg::IDLE;
                end
            endcase
        end
    end

    // PLL dynamic phase port
    always_comb begin
        pll_ctrl.phase        = phase_q;
        pll_ctrl.phasedir     = dir_q;
        pll_ctrl.phasestep    = step_fire;
        pll_ctrl.phaseloadreg = (state == memtest_pkg::LOAD);
    end

endmodule

`default_nettype wire

/* rtl/elapsed_timer.sv */
// Exact only if clk_gui equals ticks_per_sec Hz; secs wraps after 65535 and mins after 9999
`timescale 1ns/100ps
`default_nettype none

module elapsed_timer #(
    parameter int unsigned ticks_per_sec = memtest_pkg::CLK_GUI_HZ
) (
    input  wire logic             clk_gui,
    input  wire logic             timer_reset,
    output memtest_pkg::elapsed_t elapsed
);

    localparam int unsigned      PRE_W    = (ticks_per_sec > 1) ? $clog2(ticks_per_sec) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(ticks_per_sec - 1);

    logic [PRE_W-1:0] prescale;       // Cycles within the current second
    logic [5:0]       sec_in_min;     // 0..59
    logic             sec_tick;
    logic             min_tick;

    // Ripple carry through the four BCD digits
    function automatic memtest_pkg::bcd_mins_t bcd_increment(input memtest_pkg::bcd_mins_t v);
        memtest_pkg::bcd_mins_t r;
        logic                   carry;
        r     = v;
        carry = 1'b1;
        for (int d = 0; d < 4; d++) begin
            if (carry) begin
                if (r[d*4 +: 4] == 4'd9) begin
                    r[d*4 +: 4] = 4'd0;          // Carry on to next digit
                end else begin
                    r[d*4 +: 4] = r[d*4 +: 4] + 4'd1;
                    carry       = 1'b0;
                end
            end
        end
        return r;                                // 9999 rolls to 0000
    endfunction

    always_comb begin
        sec_tick = (prescale == PRE_LAST);
        min_tick = sec_tick && (sec_in_min == 6'd59);
    end

    ////////////////////
    // Counters
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            prescale     <= '0;
            sec_in_min   <= '0;
            elapsed.secs <= '0;
            elapsed.mins <= '0;
        end else begin
            if (sec_tick) begin
                prescale     <= '0;
                elapsed.secs <= elapsed.secs + 1'b1; // First tick ticks_per_sec after reset
                sec_in_min   <= min_tick ? 6'd0 : sec_in_min + 6'd1;
            end else begin
                prescale <= prescale + 1'b1;
            end
            if (min_tick) begin
                elapsed.mins <= bcd_increment(elapsed.mins);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/result_tally.sv */
// Strobes must already be synchronous one-cycle pulses in clk_gui; counts wrap at 2^32
`timescale 1ns/100ps
`default_nettype none

module result_tally (
    input  wire logic                            clk_gui,
    input  wire logic                            timer_reset,
    input  wire logic                            pass_stb,  // One pass from the tester
    input  wire logic                            fail_stb,  // One fail from the tester
    input  wire memtest_pkg::secs_t              secs,      // Current elapsed seconds
    output memtest_pkg::tally_t                  tally,
    output logic [memtest_pkg::LED_W-1:0]        led
);

    memtest_pkg::count_t fail_next;

    // LED flop tracks the updated count in the same cycle
    always_comb begin
        fail_next = tally.failcount + memtest_pkg::count_t'(fail_stb);
    end

    ////////////////////
    // Counts
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            tally.passcount <= '0;
            tally.failcount <= '0;
        end else begin
            if (pass_stb) begin
                tally.passcount <= tally.passcount + 1'b1;
            end
            tally.failcount <= fail_next;
        end
    end

    ////////////////////
    // First failure
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            tally.first_fail_valid <= 1'b0;
            tally.first_fail_secs  <= '0;
        end else if (fail_stb && !tally.first_fail_valid) begin
            tally.first_fail_valid <= 1'b1;    // Sticky until next reset
            tally.first_fail_secs  <= secs;
        end
    end

    // Low fail bits are the most useful thing on the board LEDs
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            led <= '0;
        end else begin
            led <= fail_next[memtest_pkg::LED_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/memtest_monitor_top.sv */
// All in clk_gui; tester strobes must be synchronous here and timer_reset comes in ready-made
`timescale 1ns/100ps
`default_nettype none

module memtest_monitor_top #(
    parameter int unsigned ticks_per_sec = memtest_pkg::CLK_GUI_HZ,
    parameter int unsigned debounce_bits = memtest_pkg::DEBOUNCE_BITS_DEF
) (
    input  wire logic                     clk_gui,
    input  wire logic                     timer_reset,
    input  wire logic                     btn_inc,   // Raw, phase up
    input  wire logic                     btn_dec,   // Raw, phase down
    input  wire logic                     pass_stb,
    input  wire logic                     fail_stb,
    output memtest_pkg::elapsed_t         elapsed,
    output memtest_pkg::tally_t           tally,
    output memtest_pkg::pll_ctrl_t        pll_ctrl,  // To the SDRAM clock PLL
    output logic [memtest_pkg::LED_W-1:0] led
);

    logic inc_level;
    logic dec_level;

    ////////////////////
    // Phase buttons
    ////////////////////

    btn_debounce #(.debounce_bits(debounce_bits)) debounce_inc (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn         (btn_inc),
        .level       (inc_level)
    );

    btn_debounce #(.debounce_bits(debounce_bits)) debounce_dec (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn         (btn_dec),
        .level       (dec_level)
    );

    pll_phase_stepper u_stepper (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .inc_level   (inc_level),
        .dec_level   (dec_level),
        .pll_ctrl    (pll_ctrl)
    );

    ////////////////////
    // Time and results
    ////////////////////

    elapsed_timer #(.ticks_per_sec(ticks_per_sec)) u_timer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .elapsed     (elapsed)
    );

    result_tally u_tally (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .pass_stb    (pass_stb),
        .fail_stb    (fail_stb),
        .secs        (elapsed.secs),  // Stamps the first failure
        .tally       (tally),
        .led         (led)
    );

endmodule

`default_nettype wire

/* tb/memtest_monitor_assertions.sv */
// Bound once per checked block; ports that a binding does not use are tied low there
`timescale 1ns/100ps
`default_nettype none

module memtest_monitor_assertions (
    input wire logic               clk_gui,
    input wire logic               timer_reset,
    input wire logic               inc_level,
    input wire logic               dec_level,
    input wire logic               phasestep,
    input wire logic               phaseloadreg,
    input wire logic               first_fail_valid,
    input wire memtest_pkg::secs_t first_fail_secs
);

    int unsigned failures = 0;        // Summed by the testbench at the end

    ////////////////////
    // Stepper
    ////////////////////

    // Levels already low in the cycle that decided the step
    step_after_release: assert property (@(posedge clk_gui) disable iff (timer_reset)
        $rose(phasestep) |-> (!inc_level && !dec_level && $past(!inc_level && !dec_level)))
        else begin
            $error("phasestep rose while a phase button level was high");
            failures = failures + 1;
        end

    // Load never shares a cycle with a step, nor lands right after one
    step_load_apart: assert property (@(posedge clk_gui) disable iff (timer_reset)
        phasestep |-> !phaseloadreg ##1 !phaseloadreg)
        else begin
            $error("phaseloadreg overlapped or directly followed a phasestep pulse");
            failures = failures + 1;
        end

    ////////////////////
    // Tally
    ////////////////////

    first_fail_frozen: assert property (@(posedge clk_gui) disable iff (timer_reset)
        (first_fail_valid && $past(first_fail_valid)) |-> $stable(first_fail_secs))
        else begin
            $error("first_fail_secs changed after the first failure");
            failures = failures + 1;
        end

    first_fail_sticky: assert property (@(posedge clk_gui) disable iff (timer_reset)
        $past(first_fail_valid) |-> first_fail_valid)
        else begin
            $error("first_fail_valid dropped without a reset");
            failures = failures + 1;
        end

endmodule

bind pll_phase_stepper memtest_monitor_assertions stepper_checks (
    .clk_gui          (clk_gui),
    .timer_reset      (timer_reset),
    .inc_level        (inc_level),
    .dec_level        (dec_level),
    .phasestep        (pll_ctrl.phasestep),
    .phaseloadreg     (pll_ctrl.phaseloadreg),
    .first_fail_valid (1'b0),
    .first_fail_secs  ('0)
);

bind result_tally memtest_monitor_assertions tally_checks (
    .clk_gui          (clk_gui),
    .timer_reset      (timer_reset),
    .inc_level        (1'b0),
    .dec_level        (1'b0),
    .phasestep        (1'b0),
    .phaseloadreg     (1'b0),
    .first_fail_valid (tally.first_fail_valid),
    .first_fail_secs  (tally.first_fail_secs)
);

`default_nettype wire

/* tb/tb_memtest_monitor.sv */
// Runs the monitor at ticks_per_sec 10 and debounce_bits 3; stops at the first failed check
`timescale 1ns/100ps
`default_nettype none

module tb_memtest_monitor;

    localparam int unsigned CLK_PERIOD = 8;
    localparam int unsigned TICKS      = 10;
    localparam int unsigned DEB_BITS   = 3;
    localparam int unsigned BOUNCE     = 5;           // Shorter than the 8-cycle window
    localparam int unsigned HOLD       = 20;
    localparam int unsigned WAIT_LIMIT = 100;         // Per handshake wait
    // Two resets, the 600 s timer run, tally tests, five presses, margin
    localparam int unsigned WATCHDOG_CYCLES =
        2 * 4 + 600 * TICKS + 100 + 200 + 5 * (2 * (BOUNCE + 1) + HOLD + 2 * WAIT_LIMIT) + 500;

    logic clk_gui     = 1'b0;
    logic timer_reset = 1'b1;
    logic btn_inc     = 1'b0;
    logic btn_dec     = 1'b0;
    logic pass_stb    = 1'b0;
    logic fail_stb    = 1'b0;

    memtest_pkg::elapsed_t         elapsed;
    memtest_pkg::tally_t           tally;
    memtest_pkg::pll_ctrl_t        pll_ctrl;
    logic [memtest_pkg::LED_W-1:0] led;

    int unsigned         cyc = 0;                     // Posedges since reset release
    int unsigned         exp_pass = 0;
    int unsigned         exp_fail = 0;
    int unsigned         step_count = 0;
    int unsigned         load_count = 0;
    int unsigned         bound_failures;
    memtest_pkg::phase_t exp_phase = '0;
    logic                exp_dir = 1'b0;              // Direction of the burst under test
    logic [31:0]         lfsr_state = 32'hcd28;

    memtest_monitor_top #(.ticks_per_sec(TICKS), .debounce_bits(DEB_BITS)) DUT (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn_inc     (btn_inc),
        .btn_dec     (btn_dec),
        .pass_stb    (pass_stb),
        .fail_stb    (fail_stb),
        .elapsed     (elapsed),
        .tally       (tally),
        .pll_ctrl    (pll_ctrl),
        .led         (led)
    );

    always #(CLK_PERIOD / 2) clk_gui = ~clk_gui;

    always @(posedge clk_gui) begin
        cyc <= timer_reset ? 0 : cyc + 1;
    end

    // PLL pulse monitor, sees the cycle that just ended
    always @(posedge clk_gui) begin
        if (!timer_reset && pll_ctrl.phasestep) begin
            step_count = step_count + 1;
            assert (pll_ctrl.phasedir == exp_dir)
                else report_mismatch("pulse_monitor.phasedir", exp_dir, pll_ctrl.phasedir);
            assert (!btn_inc && !btn_dec)
                else stop_with_failure("phasestep pulse while a button was still pressed");
        end
        if (!timer_reset && pll_ctrl.phaseloadreg) begin
            load_count = load_count + 1;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("mismatch in %s: expected 0x%0h, actual 0x%0h",
                                    test, expected, actual));
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else report_mismatch(test, expected, actual);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b          = lfsr_state[0];
    endtask

    // Reference time, from the cycle count alone
    function automatic memtest_pkg::secs_t model_secs(input int unsigned c);
        return memtest_pkg::secs_t'(c / TICKS);
    endfunction

    function automatic memtest_pkg::bcd_mins_t model_mins(input int unsigned c);
        int unsigned            m;
        memtest_pkg::bcd_mins_t r;
        m = (c / (60 * TICKS)) % 10000;
        for (int d = 0; d < 4; d++) begin
            r[d*4 +: 4] = 4'(m % 10);                     // Decimal digit by digit
            m           = m / 10;
        end
        return r;
    endfunction

    task automatic apply_reset();
        @(negedge clk_gui);
        timer_reset = 1'b1;
        repeat (4) @(negedge clk_gui);
        timer_reset = 1'b0;
        exp_pass    = 0;
        exp_fail    = 0;
        exp_phase   = '0;
    endtask

    task automatic wait_until_cycle(input int unsigned c);
        while (cyc < c) begin
            @(negedge clk_gui);
        end
    endtask

    task automatic check_elapsed(input string test, input int unsigned c);
        wait_until_cycle(c);
        check_value({test, ".secs"}, model_secs(c), elapsed.secs);
        check_value({test, ".mins"}, model_mins(c), elapsed.mins);
    endtask

    task automatic check_counts(input string test);
        check_value({test, ".passcount"}, exp_pass, tally.passcount);
        check_value({test, ".failcount"}, exp_fail, tally.failcount);
        check_value({test, ".led"}, exp_fail[memtest_pkg::LED_W-1:0], led);
    endtask

    task automatic pulse_fail();
        fail_stb = 1'b1;
        exp_fail = exp_fail + 1;
        @(negedge clk_gui);
        fail_stb = 1'b0;
    endtask

    task automatic set_button(input logic up, input logic value);
        if (up) begin
            btn_inc = value;
        end else begin
            btn_dec = value;
        end
    endtask

    // Random chatter, then the settled level
    task automatic bounce_to(input logic up, input logic value);
        logic b;
        repeat (BOUNCE) begin
            take_bit(b);
            set_button(up, b);
            @(negedge clk_gui);
        end
        set_button(up, value);
    endtask

    task automatic wait_for_phase(input string test, input memtest_pkg::phase_t expected);
        int unsigned n;
        n = 0;
        while (pll_ctrl.phase != expected) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure({test, ": phase count never reached the expected value"});
            end
            @(negedge clk_gui);
            n = n + 1;
        end
    endtask

    task automatic wait_for_loads(input string test, input int unsigned target);
        int unsigned n;
        n = 0;
        while (load_count < target) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure({test, ": no phaseloadreg pulse after the button release"});
            end
            @(negedge clk_gui);
            n = n + 1;
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset_state();
        check_value("reset.elapsed", 0, elapsed);
        check_value("reset.passcount", 0, tally.passcount);
        check_value("reset.failcount", 0, tally.failcount);
        check_value("reset.first_fail", 0, {tally.first_fail_valid, tally.first_fail_secs});
        check_value("reset.led", 0, led);
        check_value("reset.pll_ctrl", 0, pll_ctrl);
    endtask

    task automatic test_elapsed_time();
        for (int unsigned n = 1; n <= 5; n++) begin
            check_elapsed("elapsed.before_tick", n * TICKS - 1);
            check_elapsed("elapsed.on_tick", n * TICKS);
        end
        check_elapsed("elapsed.minute_1", 60 * TICKS - 1);
        check_elapsed("elapsed.minute_1", 60 * TICKS);
        check_elapsed("elapsed.minute_10", 600 * TICKS - 1);
        check_elapsed("elapsed.minute_10", 600 * TICKS);      // Digit carry 0009 to 0010
    endtask

    task automatic test_first_fail();
        memtest_pkg::secs_t first_secs;
        check_value("first_fail.idle", 0, tally.first_fail_valid);
        wait_until_cycle(3 * TICKS + 5);
        first_secs = model_secs(cyc);                       // Second when the strobe lands
        pulse_fail();
        check_value("first_fail.valid", 1, tally.first_fail_valid);
        check_value("first_fail.secs", first_secs, tally.first_fail_secs);
        for (int unsigned k = 5; k <= 8; k += 3) begin
            wait_until_cycle(k * TICKS + 7);
            pulse_fail();
            check_value("first_fail.later_valid", 1, tally.first_fail_valid);
            check_value("first_fail.later_secs", first_secs, tally.first_fail_secs);
        end
        check_counts("first_fail");
    endtask

    task automatic test_random_tally();
        logic p;
        logic f;
        for (int i = 0; i < 200; i++) begin
            check_counts("random_tally");
            take_bit(p);
            take_bit(f);
            pass_stb = p;
            fail_stb = f;
            exp_pass = exp_pass + p;
            exp_fail = exp_fail + f;
            @(negedge clk_gui);
        end
        pass_stb = 1'b0;
        fail_stb = 1'b0;
        check_counts("random_tally.last");
        @(negedge clk_gui);
        check_counts("random_tally.idle");
    endtask

    // Each release sends its own burst, so one step and one load per press
    task automatic test_phase_presses(input string test, input logic up,
                                      input int unsigned presses);
        int unsigned steps_at_start;
        int unsigned loads_at_start;
        steps_at_start = step_count;
        loads_at_start = load_count;
        exp_dir        = up;
        for (int unsigned i = 0; i < presses; i++) begin
            bounce_to(up, 1'b1);
            exp_phase = up ? exp_phase + 1'b1 : exp_phase - 1'b1;
            wait_for_phase(test, exp_phase);
            repeat (HOLD) @(negedge clk_gui);               // Held, PLL must stay still
            check_value({test, ".phase_held"}, exp_phase, pll_ctrl.phase);
            check_value({test, ".steps_held"}, steps_at_start + i, step_count);
            bounce_to(up, 1'b0);
            wait_for_loads(test, loads_at_start + i + 1);
            check_value({test, ".steps"}, steps_at_start + i + 1, step_count);
        end
        repeat (HOLD) @(negedge clk_gui);
        check_value({test, ".total_steps"}, steps_at_start + presses, step_count);
        check_value({test, ".total_loads"}, loads_at_start + presses, load_count);
        check_value({test, ".phase"}, exp_phase, pll_ctrl.phase);
    endtask

    ////////////////////
    // Run
    ////////////////////

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        apply_reset();
        test_reset_state();
        test_elapsed_time();
        apply_reset();
        test_first_fail();
        test_random_tally();
        test_phase_presses("phase_inc", 1'b1, 3);     // Phase 0 to 3
        test_phase_presses("phase_dec", 1'b0, 2);     // Phase 3 to 1
        bound_failures = DUT.u_stepper.stepper_checks.failures
                       + DUT.u_tally.tally_checks.failures;
        if (bound_failures == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d bound assertion failures", bound_failures));
        end
    end

endmodule

`default_nettype wire

/* project.f */
rtl/memtest_pkg.sv
rtl/btn_debounce.sv
rtl/pll_phase_stepper.sv
rtl/elapsed_timer.sv
rtl/result_tally.sv
rtl/memtest_monitor_top.sv
tb/memtest_monitor_assertions.sv
tb/tb_memtest_monitor.sv
